/* test/decode_input.txt */
# name inst(hex) op(dec) off byte_val src dst rc wb prpo dec inc
# src_used src_only dst_used reg_set reg_dep (all hex except op)
bl_off       1abc  1 1abc 00 0 0 0 0 0 0 0 0 0 0 00 00
bl_zero      0000  1 0000 00 0 0 0 0 0 0 0 0 0 0 00 00
beq          2155  2 0155 00 0 0 0 0 0 0 0 0 0 0 00 00
bne          27ff  3 03ff 00 0 0 0 0 0 0 0 0 0 0 00 00
bc           2801  4 0001 00 0 0 0 0 0 0 0 0 0 0 00 00
bnc          2e00  5 0200 00 0 0 0 0 0 0 0 0 0 0 00 00
bn           30aa  6 00aa 00 0 0 0 0 0 0 0 0 0 0 00 00
bge          3523  7 0123 00 0 0 0 0 0 0 0 0 0 0 00 00
blt          3b00  8 0300 00 0 0 0 0 0 0 0 0 0 0 00 00
bra          3cff  9 00ff 00 0 0 0 0 0 0 0 0 0 0 00 00
add_reg      401d 10 0000 00 3 5 0 0 0 0 0 1 0 1 28 28
add_const    40fa 10 0000 00 7 2 1 1 0 0 0 0 0 1 04 04
addc         4109 11 0000 00 1 1 0 0 0 0 0 1 0 1 02 02
sub_byte     4247 12 0000 00 0 7 0 1 0 0 0 1 0 1 81 81
subc         4334 13 0000 00 6 4 0 0 0 0 0 1 0 1 50 50
dadd_const   4496 14 0000 00 2 6 1 0 0 0 0 0 0 1 40 40
cmp          4521 15 0000 00 4 1 0 0 0 0 0 1 1 1 00 12
xor          4628 16 0000 00 5 0 0 0 0 0 0 1 0 1 21 21
and_byte     4753 17 0000 00 2 3 0 1 0 0 0 1 0 1 0c 0c
or_const     488f 18 0000 00 1 7 1 0 0 0 0 0 0 1 80 80
bit_reg      493e 19 0000 00 7 6 0 0 0 0 0 1 1 1 00 c0
bit_const    4983 19 0000 00 0 3 1 0 0 0 0 0 1 1 00 08
bic          4a1a 20 0000 00 3 2 0 0 0 0 0 1 0 1 0c 0c
bis_byte     4b71 21 0000 00 6 1 0 1 0 0 0 1 0 1 42 42
mov_byte     4c62 22 0000 00 4 2 0 1 0 0 0 1 0 0 14 10
swap         4c8e 23 0000 00 1 6 0 0 0 0 0 1 0 1 42 42
ld_pre_inc   5a95 24 0000 00 2 5 0 0 1 0 1 1 0 1 24 24
st_post_dec  5d58 25 0000 00 3 0 0 1 0 1 0 1 1 1 00 09
movl         652b 26 0000 a5 0 3 0 0 0 0 0 0 0 0 08 00
movlz        6fff 27 0000 ff 0 7 0 0 0 0 0 0 0 0 80 00
movls        71e0 28 0000 3c 0 0 0 0 0 0 0 0 0 0 01 00
movh         7c0c 29 0000 81 0 4 0 0 0 0 0 0 0 0 10 00
sra_dropped  4d02  0 0000 00 0 0 0 0 0 0 0 0 0 0 00 00
svc_dropped  4d95  0 0000 00 0 0 0 0 0 0 0 0 0 0 00 00
setcc_drop   4db3  0 0000 00 0 0 0 0 0 0 0 0 0 0 00 00
ldr_dropped  8abc  0 0000 00 0 0 0 0 0 0 0 0 0 0 00 00

/* list.f */
design/decode_pkg.sv
design/opcode_match.sv
design/operand_extract.sv
design/hazard_mask.sv
design/decode_stage.sv
test/clock_gen.sv
test/decode_checker.sv
test/decode_stage_sva.sv
test/tb_decode_stage.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_decode_stage
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= No errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* test/tb_decode_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_decode_stage;

    localparam int    CLK_PERIOD   = 8;
    localparam int    RESET_CYCLES = 4;
    localparam string DATA_FILE    = "test/decode_input.txt";

    logic                 clk;
    logic                 reset;
    logic                 inst_valid;
    decode_pkg::inst_t    inst;
    logic                 out_valid;
    decode_pkg::decoded_t decoded;
    int                   checked;
    int                   check_errors;
    decode_pkg::inst_t    vectors[$];
    logic                 loaded = 1'b0;
    logic                 load_failed = 1'b0;
    logic                 timed_out = 1'b0;

    clock_gen i_clk (
        .clk   (clk),
        .reset (reset)
    );

    decode_stage i_dut (
        .clk        (clk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst       (inst),
        .out_valid  (out_valid),
        .decoded    (decoded)
    );

    decode_checker i_check (
        .clk       (clk),
        .out_valid (out_valid),
        .decoded   (decoded),
        .checked   (checked),
        .errors    (check_errors)
    );

    // only name and instruction word, the checker reads the rest
    task automatic load_vectors();
        int                fd;
        string             line;
        string             name;
        decode_pkg::inst_t word;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("cannot open data file %s", DATA_FILE);
            load_failed = 1'b1;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) == 0) break;
                if (line.len() < 2 || line.getc(0) == "#") continue;
                if ($sscanf(line, "%s %h", name, word) == 2) begin
                    vectors.push_back(word);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic finish_run();
        int total;
        total = check_errors + i_dut.i_sva.fail_count + int'(load_failed) + int'(timed_out);
        $display("outputs checked %0d of %0d, errors %0d", checked, vectors.size(), total);
        if (total == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    initial begin
        inst_valid = 1'b0;
        inst       = '0;
        load_vectors();
        loaded = 1'b1;
        if (load_failed) begin
            finish_run();
        end else begin
            @(negedge clk);
            wait (!reset);
            @(negedge clk);
            foreach (vectors[i]) begin   // back to back, one per cycle
                inst_valid = 1'b1;
                inst       = vectors[i];
                @(negedge clk);
            end
            inst_valid = 1'b0;
            inst       = '0;
            while (checked < vectors.size()) @(negedge clk);
            repeat (3) @(negedge clk);   // room for a stray extra output
            finish_run();
        end
    end

    // watchdog
    initial begin
        wait (loaded);
        #((vectors.size() + RESET_CYCLES + 10) * CLK_PERIOD);
        $display("timeout, only %0d of %0d outputs arrived", checked, vectors.size());
        timed_out = 1'b1;
        finish_run();
    end

endmodule

`default_nettype wire

/* test/decode_stage_sva.sv */
`timescale 1ns/100ps
`default_nettype none

module decode_stage_sva (
    input wire                       clk,
    input wire                       reset,
    input wire                       inst_valid,
    input wire                       out_valid,
    input wire decode_pkg::decoded_t decoded
);

    int reset_fails   = 0;
    int latency_fails = 0;
    int mask_fails    = 0;
    int fail_count;

    assign fail_count = reset_fails + latency_fails + mask_fails;

    // pipeline flushed by reset
    a_reset_quiet: assert property (@(posedge clk) reset |=> !out_valid)
        else begin
            $error("out_valid high after a reset cycle");
            reset_fails++;
        end

    // fixed three stage latency
    a_latency: assert property (@(posedge clk) disable iff (reset)
                                out_valid == $past(inst_valid, 3))
        else begin
            $error("out_valid does not follow inst_valid by three cycles");
            latency_fails++;
        end

    a_none_masks: assert property (@(posedge clk)
                                   decoded.op == decode_pkg::op_none |->
                                   decoded.reg_set == '0 && decoded.reg_dep == '0)
        else begin
            $error("register masks not zero for op_none");
            mask_fails++;
        end

endmodule

bind decode_stage decode_stage_sva i_sva (
    .clk        (clk),
    .reset      (reset),
    .inst_valid (inst_valid),
    .out_valid  (out_valid),
    .decoded    (decoded)
);

`default_nettype wire

/* test/decode_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module decode_checker (
    input  wire                  clk,
    input  wire                  out_valid,
    input  wire decode_pkg::decoded_t decoded,
    output int                   checked,
    output int                   errors
);

    localparam string DATA_FILE = "test/decode_input.txt";

    string                names[$];
    decode_pkg::decoded_t expected[$];
    int                   seen = 0;
    int                   mismatch_count = 0;
    int                   file_errors = 0;

    assign checked = seen;
    assign errors  = mismatch_count + file_errors;

    initial begin
        int                fd;
        int                n;
        string             line;
        string             name;
        logic [15:0]       col [16];
        decode_pkg::decoded_t exp_d;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("cannot open data file %s", DATA_FILE);
            file_errors = 1;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) == 0) break;
                if (line.len() < 2 || line.getc(0) == "#") continue;   // blank or comment
                n = $sscanf(line, "%s %h %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            name, col[0], col[1], col[2], col[3], col[4], col[5],
                            col[6], col[7], col[8], col[9], col[10], col[11],
                            col[12], col[13], col[14], col[15]);
                if (n != 17) begin
                    $display("bad line in data file: %s", line);
                    file_errors++;
                    continue;
                end
                exp_d                 = '0;
                exp_d.op              = decode_pkg::op_t'(col[1][5:0]);
                exp_d.fields.off      = col[2][12:0];
                exp_d.fields.byte_val = col[3][7:0];
                exp_d.fields.src      = col[4][2:0];
                exp_d.fields.dst      = col[5][2:0];
                exp_d.fields.rc       = col[6][0];
                exp_d.fields.wb       = col[7][0];
                exp_d.fields.prpo     = col[8][0];
                exp_d.fields.dec      = col[9][0];
                exp_d.fields.inc      = col[10][0];
                exp_d.fields.src_used = col[11][0];
                exp_d.fields.src_only = col[12][0];
                exp_d.fields.dst_used = col[13][0];
                exp_d.reg_set         = col[14][7:0];
                exp_d.reg_dep         = col[15][7:0];
                names.push_back(name);
                expected.push_back(exp_d);
            end
            $fclose(fd);
        end
    end

    task automatic compare_value(input string test, input string what,
                                 input logic [15:0] exp_v, input logic [15:0] act_v);
        if (exp_v !== act_v) begin
            $display("Mismatch %s %s: expected %0h, actual %0h", test, what, exp_v, act_v);
            mismatch_count++;
        end
    endtask

    task automatic compare_output(input string test, input decode_pkg::decoded_t e,
                                  input decode_pkg::decoded_t a);
        compare_value(test, "op", 16'(e.op), 16'(a.op));
        compare_value(test, "off", 16'(e.fields.off), 16'(a.fields.off));
        compare_value(test, "byte_val", 16'(e.fields.byte_val), 16'(a.fields.byte_val));
        compare_value(test, "src", 16'(e.fields.src), 16'(a.fields.src));
        compare_value(test, "dst", 16'(e.fields.dst), 16'(a.fields.dst));
        compare_value(test, "rc", 16'(e.fields.rc), 16'(a.fields.rc));
        compare_value(test, "wb", 16'(e.fields.wb), 16'(a.fields.wb));
        compare_value(test, "prpo", 16'(e.fields.prpo), 16'(a.fields.prpo));
        compare_value(test, "dec", 16'(e.fields.dec), 16'(a.fields.dec));
        compare_value(test, "inc", 16'(e.fields.inc), 16'(a.fields.inc));
        compare_value(test, "src_used", 16'(e.fields.src_used), 16'(a.fields.src_used));
        compare_value(test, "src_only", 16'(e.fields.src_only), 16'(a.fields.src_only));
        compare_value(test, "dst_used", 16'(e.fields.dst_used), 16'(a.fields.dst_used));
        compare_value(test, "reg_set", 16'(e.reg_set), 16'(a.reg_set));
        compare_value(test, "reg_dep", 16'(e.reg_dep), 16'(a.reg_dep));
    endtask

    // outputs settle after the rising edge, read them on the falling one
    always @(negedge clk) begin
        if (out_valid) begin
            if (seen >= expected.size()) begin
                $display("unexpected output number %0d, the data file has only %0d vectors",
                         seen + 1, expected.size());
                mismatch_count++;
            end else begin
                compare_output(names[seen], expected[seen], decoded);
            end
            seen++;
        end
    end

endmodule

`default_nettype wire

/* test/clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module clock_gen (
    output logic clk,
    output logic reset
);

    localparam int HALF_PERIOD  = 4;   // 8 ns clock
    localparam int RESET_CYCLES = 4;

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;   // released on a falling edge
    end

    always #HALF_PERIOD clk = ~clk;

endmodule

`default_nettype wire

/* design/decode_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    inst_valid,
    input  wire decode_pkg::inst_t inst,
    output logic                   out_valid,
    output decode_pkg::decoded_t   decoded
);

    logic                   match_valid;
    decode_pkg::matched_t   matched;
    logic                   extract_valid;
    decode_pkg::extracted_t extracted;

    // stage 1, opcode by priority compare
    opcode_match i_match (
        .clk         (clk),
        .reset       (reset),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .match_valid (match_valid),
        .matched     (matched)
    );

    // stage 2, operand fields
    operand_extract i_extract (
        .clk           (clk),
        .reset         (reset),
        .match_valid   (match_valid),
        .matched       (matched),
        .extract_valid (extract_valid),
        .extracted     (extracted)
    );

    // stage 3, set and dependency masks
    hazard_mask i_hazard (
        .clk           (clk),
        .reset         (reset),
        .extract_valid (extract_valid),
        .extracted     (extracted),
        .out_valid     (out_valid),
        .decoded       (decoded)
    );

endmodule

`default_nettype wire

/* design/hazard_mask.sv */
`timescale 1ns/100ps
`default_nettype none

module hazard_mask (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      extract_valid,
    input  wire decode_pkg::extracted_t extracted,
    output logic                     out_valid,
    output decode_pkg::decoded_t     decoded
);

    decode_pkg::fields_t   f;
    decode_pkg::reg_mask_t set_next;
    decode_pkg::reg_mask_t dep_next;
    logic                  has_regs;

    assign f = extracted.fields;

    // none and the branches sit below op_add and name no registers
    assign has_regs = (extracted.op >= decode_pkg::op_add);

    always_comb begin
        set_next = '0;
        dep_next = '0;
        if (has_regs) begin
            if (f.src_used) begin
                dep_next[f.src] = 1'b1;
                if (!f.src_only) begin
                    set_next[f.src] = 1'b1;
                end
            end
            if (!f.src_only) begin
                set_next[f.dst] = 1'b1;   // written by this instruction
            end
            if (f.dst_used) begin
                dep_next[f.dst] = 1'b1;   // old value read
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            decoded   <= '0;
        end else begin
            out_valid       <= extract_valid;
            decoded.op      <= extracted.op;
            decoded.fields  <= f;
            decoded.reg_set <= set_next;
            decoded.reg_dep <= dep_next;
        end
    end

endmodule

`default_nettype wire

/* design/operand_extract.sv */
`timescale 1ns/100ps
`default_nettype none

module operand_extract (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    match_valid,
    input  wire decode_pkg::matched_t matched,
    output logic                   extract_valid,
    output decode_pkg::extracted_t extracted
);

    decode_pkg::inst_t   inst;
    decode_pkg::fields_t f;

    assign inst = matched.inst;

    always_comb begin
        f = '0;   // fields outside the format stay zero
        case (matched.op)
            decode_pkg::op_bl: begin
                f.off = inst[12:0];
            end
            decode_pkg::op_beq, decode_pkg::op_bne, decode_pkg::op_bc,
            decode_pkg::op_bnc, decode_pkg::op_bn, decode_pkg::op_bge,
            decode_pkg::op_blt, decode_pkg::op_bra: begin
                f.off = {3'b000, inst[9:0]};
            end
            decode_pkg::op_add, decode_pkg::op_addc, decode_pkg::op_sub,
            decode_pkg::op_subc, decode_pkg::op_dadd, decode_pkg::op_cmp,
            decode_pkg::op_xor, decode_pkg::op_and, decode_pkg::op_or,
            decode_pkg::op_bit, decode_pkg::op_bic, decode_pkg::op_bis: begin
                f.rc       = inst[7];
                f.wb       = inst[6];
                f.src      = inst[5:3];
                f.dst      = inst[2:0];
                f.src_used = ~inst[7];   // constant in src slot names no register
                f.dst_used = 1'b1;
                // compare and bit test only set flags
                f.src_only = (matched.op == decode_pkg::op_cmp) ||
                             (matched.op == decode_pkg::op_bit);
            end
            decode_pkg::op_mov: begin
                f.wb       = inst[6];
                f.src      = inst[5:3];
                f.dst      = inst[2:0];
                f.src_used = 1'b1;
            end
            decode_pkg::op_swap: begin
                f.src      = inst[5:3];
                f.dst      = inst[2:0];
                f.src_used = 1'b1;
                f.dst_used = 1'b1;
            end
            decode_pkg::op_ld, decode_pkg::op_st: begin
                f.prpo     = inst[9];
                f.dec      = inst[8];
                f.inc      = inst[7];
                f.wb       = inst[6];
                f.src      = inst[5:3];
                f.dst      = inst[2:0];
                f.src_used = 1'b1;   // address reg, may be stepped
                f.dst_used = 1'b1;
                f.src_only = (matched.op == decode_pkg::op_st);   // store writes no register
            end
            decode_pkg::op_movl, decode_pkg::op_movlz,
            decode_pkg::op_movls, decode_pkg::op_movh: begin
                f.byte_val = inst[10:3];
                f.dst      = inst[2:0];
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            extract_valid <= 1'b0;
            extracted     <= '0;
        end else begin
            extract_valid    <= match_valid;
            extracted.op     <= matched.op;
            extracted.fields <= f;
        end
    end

endmodule

`default_nettype wire

/* design/opcode_match.sv */
`timescale 1ns/100ps
`default_nettype none

module opcode_match (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  inst_valid,
    input  wire decode_pkg::inst_t inst,
    output logic                 match_valid,
    output decode_pkg::matched_t matched
);

    decode_pkg::op_t op_next;

    // walked backwards so the lowest table index wins
    always_comb begin
        op_next = decode_pkg::op_none;   // dropped and undefined encodings
        for (int i = decode_pkg::N_OPS - 1; i >= 0; i--) begin
            if ((inst & decode_pkg::op_table[i].mask) ==
                decode_pkg::op_table[i].value) begin
                op_next = decode_pkg::op_table[i].op;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            match_valid <= 1'b0;
            matched     <= '0;
        end else begin
            match_valid  <= inst_valid;
            matched.op   <= op_next;
            matched.inst <= inst;     // raw word kept for field extraction
        end
    end

endmodule

`default_nettype wire

/* design/decode_pkg.sv */
`default_nettype none

package decode_pkg;

    typedef logic [15:0] inst_t;
    typedef logic [2:0]  reg_idx_t;
    typedef logic [7:0]  reg_mask_t;

    // value of each name is its priority position, none first
    typedef enum logic [5:0] {
        op_none,
        op_bl,
        op_beq, op_bne, op_bc, op_bnc, op_bn, op_bge, op_blt, op_bra,
        op_add, op_addc, op_sub, op_subc, op_dadd, op_cmp,
        op_xor, op_and, op_or, op_bit, op_bic, op_bis,
        op_mov, op_swap,
        op_ld, op_st,
        op_movl, op_movlz, op_movls, op_movh
    } op_t;

    typedef struct packed {
        op_t   op;
        inst_t mask;
        inst_t value;   // inst & mask must equal this
    } op_pattern_t;

    localparam int N_OPS = 29;

    localparam op_pattern_t op_table [N_OPS] = '{
        '{op_bl,    16'b1110_0000_0000_0000, 16'b0000_0000_0000_0000},
        '{op_beq,   16'b1111_1100_0000_0000, 16'b0010_0000_0000_0000},
        '{op_bne,   16'b1111_1100_0000_0000, 16'b0010_0100_0000_0000},
        '{op_bc,    16'b1111_1100_0000_0000, 16'b0010_1000_0000_0000},
        '{op_bnc,   16'b1111_1100_0000_0000, 16'b0010_1100_0000_0000},
        '{op_bn,    16'b1111_1100_0000_0000, 16'b0011_0000_0000_0000},
        '{op_bge,   16'b1111_1100_0000_0000, 16'b0011_0100_0000_0000},
        '{op_blt,   16'b1111_1100_0000_0000, 16'b0011_1000_0000_0000},
        '{op_bra,   16'b1111_1100_0000_0000, 16'b0011_1100_0000_0000},
        '{op_add,   16'b1111_1111_0000_0000, 16'b0100_0000_0000_0000},
        '{op_addc,  16'b1111_1111_0000_0000, 16'b0100_0001_0000_0000},
        '{op_sub,   16'b1111_1111_0000_0000, 16'b0100_0010_0000_0000},
        '{op_subc,  16'b1111_1111_0000_0000, 16'b0100_0011_0000_0000},
        '{op_dadd,  16'b1111_1111_0000_0000, 16'b0100_0100_0000_0000},
        '{op_cmp,   16'b1111_1111_0000_0000, 16'b0100_0101_0000_0000},
        '{op_xor,   16'b1111_1111_0000_0000, 16'b0100_0110_0000_0000},
        '{op_and,   16'b1111_1111_0000_0000, 16'b0100_0111_0000_0000},
        '{op_or,    16'b1111_1111_0000_0000, 16'b0100_1000_0000_0000},
        '{op_bit,   16'b1111_1111_0000_0000, 16'b0100_1001_0000_0000},
        '{op_bic,   16'b1111_1111_0000_0000, 16'b0100_1010_0000_0000},
        '{op_bis,   16'b1111_1111_0000_0000, 16'b0100_1011_0000_0000},
        '{op_mov,   16'b1111_1111_1000_0000, 16'b0100_1100_0000_0000},
        '{op_swap,  16'b1111_1111_1000_0000, 16'b0100_1100_1000_0000},
        '{op_ld,    16'b1111_1100_0000_0000, 16'b0101_1000_0000_0000},
        '{op_st,    16'b1111_1100_0000_0000, 16'b0101_1100_0000_0000},
        '{op_movl,  16'b1111_1000_0000_0000, 16'b0110_0000_0000_0000},
        '{op_movlz, 16'b1111_1000_0000_0000, 16'b0110_1000_0000_0000},
        '{op_movls, 16'b1111_1000_0000_0000, 16'b0111_0000_0000_0000},
        '{op_movh,  16'b1111_1000_0000_0000, 16'b0111_1000_0000_0000}
    };

    typedef struct packed {
        logic [12:0] off;        // branch offset, zero-extended
        logic [7:0]  byte_val;   // byte-move literal
        reg_idx_t    src;
        reg_idx_t    dst;
        logic        rc;         // 1 = constant in src slot
        logic        wb;         // 1 = byte op
        logic        prpo;
        logic        dec;
        logic        inc;
        logic        src_used;   // src names a real register
        logic        src_only;   // dst only read, never written
        logic        dst_used;   // dst read as well as written
    } fields_t;

    typedef struct packed {
        op_t       op;
        fields_t   fields;
        reg_mask_t reg_set;
        reg_mask_t reg_dep;
    } decoded_t;

    typedef struct packed {
        op_t   op;
        inst_t inst;
    } matched_t;

    typedef struct packed {
        op_t     op;
        fields_t fields;
    } extracted_t;

endpackage

`default_nettype wire
